// ==== Makefile ====
# Verilator build and run of the uart2 testbench
TOP := uart2_tb

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f uart2.f -Mdir obj_dir

# Run and keep the log; the pass line decides the exit status
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -qx "Test passed" sim.log || (echo "Simulation did not pass, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== logic/uart2_pkg.sv ====
/* Register map and shared widths of the uart2 peripheral
   Four 16-bit registers. Only the low byte of the data register is used */
package uart2_pkg;

	// One serial character
	typedef logic [7:0] uart_byte_t;
	// Wishbone data word
	typedef logic [15:0] uart_word_t;
	// Word address of a register
	typedef logic [1:0] uart_addr_t;
	// Baud divisor, tick period is div+1 cycles
	typedef logic [15:0] uart_div_t;

	// Register addresses
	localparam uart_addr_t ADDR_DATA = 2'd0;
	localparam uart_addr_t ADDR_CTRL = 2'd1;
	localparam uart_addr_t ADDR_STAT = 2'd2;
	localparam uart_addr_t ADDR_DIV  = 2'd3;

	// Control register bits
	localparam int CTRL_PAREN = 0;
	localparam int CTRL_EVEN  = 1;
	localparam int CTRL_POL   = 2;
	localparam int CTRL_BRK   = 3;

	// Status register bits, read only
	localparam int STAT_TBE   = 0;
	localparam int STAT_TIDLE = 1;
	localparam int STAT_RBF   = 2;
	localparam int STAT_PERR  = 3;
	localparam int STAT_FERR  = 4;
	localparam int STAT_OVR   = 5;

endpackage

// ==== logic/uart2_top.sv ====
`timescale 1ns/1ps
/* uart2 peripheral, Wishbone classic slave with one serial port
   No FIFOs or interrupts; software polls the status register */
module uart2_top #(
	parameter uart2_pkg::uart_div_t DIV_RESET = 16'd3
) (
	input  logic                  sys_clk,
	input  logic                  resetl,
	input  logic                  cyc,
	input  logic                  stb,
	input  logic                  we,
	input  uart2_pkg::uart_addr_t adr,
	input  uart2_pkg::uart_word_t dat_w,
	output uart2_pkg::uart_word_t dat_r,
	output logic                  ack,
	output logic                  serout,
	input  logic                  serin
);
	import uart2_pkg::*;

	// Control from the register block
	logic       paren;
	logic       even;
	logic       pol;
	logic       brk;
	uart_div_t  div;
	// Transmit side
	uart_byte_t tx_data;
	logic       tx_wr;
	logic       tbe;
	logic       tidle;
	// Receive side
	uart_byte_t rx_data;
	logic       rx_rd;
	logic       rbf;
	logic       perr;
	logic       ferr;
	logic       ovr;
	// Shared 16x tick
	logic       tick16;

	uart_regs #(
		.DIV_RESET(DIV_RESET)
	) u_regs (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.paren(paren),
		.even(even),
		.pol(pol),
		.brk(brk),
		.div(div),
		.tx_data(tx_data),
		.tx_wr(tx_wr),
		.rx_rd(rx_rd),
		.tbe(tbe),
		.tidle(tidle),
		.rx_data(rx_data),
		.rbf(rbf),
		.perr(perr),
		.ferr(ferr),
		.ovr(ovr)
	);

	uart_baud_gen u_baud (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.div(div),
		.tick16(tick16)
	);

	uart_txer u_txer (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.tick16(tick16),
		.tx_data(tx_data),
		.tx_wr(tx_wr),
		.paren(paren),
		.even(even),
		.pol(pol),
		.brk(brk),
		.serout(serout),
		.tbe(tbe),
		.tidle(tidle)
	);

	uart_rxer u_rxer (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.tick16(tick16),
		.serin(serin),
		.paren(paren),
		.even(even),
		.pol(pol),
		.rx_rd(rx_rd),
		.rx_data(rx_data),
		.rbf(rbf),
		.perr(perr),
		.ferr(ferr),
		.ovr(ovr)
	);

endmodule

// ==== logic/uart_baud_gen.sv ====
`timescale 1ns/1ps
/* 16x baud tick, one cycle wide, every div+1 cycles
   A new divisor is picked up only when the counter next wraps */
module uart_baud_gen (
	input  logic                 sys_clk,
	input  logic                 resetl,
	input  uart2_pkg::uart_div_t div,
	output logic                 tick16
);
	import uart2_pkg::*;

	uart_div_t cnt;

	// Down-counter, zero is the tick cycle
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cnt <= '0;
		end else if (cnt == '0) begin
			// Reload here, so a divisor change waits for the wrap
			cnt <= div;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// First tick comes on the cycle after reset
	assign tick16 = (cnt == '0);

endmodule

// ==== logic/uart_regs.sv ====
`timescale 1ns/1ps
/* Wishbone classic slave, ack one cycle after the request, never back to back
   Upper bits of written words are ignored and read back as zero */
module uart_regs #(
	parameter uart2_pkg::uart_div_t DIV_RESET = 16'd3
) (
	input  logic                  sys_clk,
	input  logic                  resetl,
	input  logic                  cyc,
	input  logic                  stb,
	input  logic                  we,
	input  uart2_pkg::uart_addr_t adr,
	input  uart2_pkg::uart_word_t dat_w,
	output uart2_pkg::uart_word_t dat_r,
	output logic                  ack,
	output logic                  paren,
	output logic                  even,
	output logic                  pol,
	output logic                  brk,
	output uart2_pkg::uart_div_t  div,
	output uart2_pkg::uart_byte_t tx_data,
	output logic                  tx_wr,
	output logic                  rx_rd,
	input  logic                  tbe,
	input  logic                  tidle,
	input  uart2_pkg::uart_byte_t rx_data,
	input  logic                  rbf,
	input  logic                  perr,
	input  logic                  ferr,
	input  logic                  ovr
);
	import uart2_pkg::*;

	logic              req;
	logic              wr_en;
	logic              rd_en;
	logic [CTRL_BRK:0] ctrl;
	uart_word_t        stat;

	// New request; the ack cycle itself is not a second request
	assign req   = cyc && stb && !ack;
	assign wr_en = req && we;
	assign rd_en = req && !we;

	// Single-cycle ack on the edge after the request
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			ack <= 1'b0;
		end else begin
			ack <= req;
		end
	end

	// Control and divisor, written on the ack edge
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			ctrl <= '0;
			div  <= DIV_RESET;
		end else if (wr_en) begin
			if (adr == ADDR_CTRL) begin
				ctrl <= dat_w[CTRL_BRK:0];
			end
			if (adr == ADDR_DIV) begin
				div <= dat_w;
			end
		end
	end

	assign paren = ctrl[CTRL_PAREN];
	assign even  = ctrl[CTRL_EVEN];
	assign pol   = ctrl[CTRL_POL];
	assign brk   = ctrl[CTRL_BRK];

	// Data strobes land on the same edge as the ack
	assign tx_wr   = wr_en && (adr == ADDR_DATA);
	assign tx_data = dat_w[7:0];
	assign rx_rd   = rd_en && (adr == ADDR_DATA);

	// Status word
	always_comb begin
		stat             = '0;
		stat[STAT_TBE]   = tbe;
		stat[STAT_TIDLE] = tidle;
		stat[STAT_RBF]   = rbf;
		stat[STAT_PERR]  = perr;
		stat[STAT_FERR]  = ferr;
		stat[STAT_OVR]   = ovr;
	end

	// Read data, valid while ack is high
	always_ff @(posedge sys_clk) begin
		if (rd_en) begin
			case (adr)
				ADDR_DATA: dat_r <= uart_word_t'(rx_data);
				ADDR_CTRL: dat_r <= uart_word_t'(ctrl);
				ADDR_STAT: dat_r <= stat;
				default:   dat_r <= div;
			endcase
		end
	end

endmodule

// ==== logic/uart_rxer.sv ====
`timescale 1ns/1ps
/* Receives start, 8 data bits, optional parity, one stop bit at 16x oversampling
   One data register only; a frame arriving while rbf is set flags overrun */
module uart_rxer (
	input  logic                  sys_clk,
	input  logic                  resetl,
	input  logic                  tick16,
	input  logic                  serin,
	input  logic                  paren,
	input  logic                  even,
	input  logic                  pol,
	input  logic                  rx_rd,
	output uart2_pkg::uart_byte_t rx_data,
	output logic                  rbf,
	output logic                  perr,
	output logic                  ferr,
	output logic                  ovr
);
	import uart2_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		START,
		DATA,
		PARITY,
		STOP
	} rx_state_t;

	rx_state_t  state;
	logic       sync1;
	logic       sync2;
	logic       rxd;
	logic       rxd_q;
	logic [3:0] phase;
	logic [2:0] bitcnt;
	uart_byte_t shreg;
	logic       par;
	logic       par_bad;
	logic       start_ok;
	logic       mid;
	logic       done;

	// Two-flop synchronizer plus the previous level for edge detect
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			// Control clears on reset, so the line idles high
			sync1 <= 1'b1;
			sync2 <= 1'b1;
			rxd_q <= 1'b1;
		end else begin
			sync1 <= serin;
			sync2 <= sync1;
			rxd_q <= rxd;
		end
	end

	// Line level with polarity removed
	assign rxd = sync2 ^ pol;

	// Middle of the start bit, 8 ticks after the falling edge
	assign start_ok = (state == START) && tick16 && (phase == 4'd7) && !rxd;
	// Middle of every later bit, 16 ticks on
	assign mid  = tick16 && (phase == 4'd15);
	assign done = mid && (state == STOP);

	// Frame sequencer
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state  <= IDLE;
			phase  <= '0;
			bitcnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					phase  <= '0;
					bitcnt <= '0;
					if (rxd_q && !rxd) begin
						state <= START;
					end
				end
				START: begin
					if (tick16) begin
						if (phase == 4'd7) begin
							// Glitch shorter than half a bit goes back to idle
							phase <= '0;
							state <= rxd ? IDLE : DATA;
						end else begin
							phase <= phase + 4'd1;
						end
					end
				end
				DATA: begin
					if (tick16) begin
						phase <= phase + 4'd1;
					end
					if (mid) begin
						bitcnt <= bitcnt + 3'd1;
						if (bitcnt == 3'd7) begin
							state <= paren ? PARITY : STOP;
						end
					end
				end
				PARITY: begin
					if (tick16) begin
						phase <= phase + 4'd1;
					end
					if (mid) begin
						state <= STOP;
					end
				end
				default: begin
					if (tick16) begin
						phase <= phase + 4'd1;
					end
					if (mid) begin
						state <= IDLE;
					end
				end
			endcase
		end
	end

	// Data shifter and parity check, same rule as the transmitter
	always_ff @(posedge sys_clk) begin
		if (start_ok) begin
			par <= ~even;
		end else if (mid && (state == DATA)) begin
			shreg <= {rxd, shreg[7:1]};
			par   <= par ^ rxd;
		end else if (mid && (state == PARITY)) begin
			par_bad <= (rxd != par);
		end
	end

	// Received data register, replaced on overrun
	always_ff @(posedge sys_clk) begin
		if (done) begin
			rx_data <= shreg;
		end
	end

	// Status flags describe the latest frame, cleared by a data read
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			rbf  <= 1'b0;
			perr <= 1'b0;
			ferr <= 1'b0;
			ovr  <= 1'b0;
		end else if (done) begin
			rbf  <= 1'b1;
			// Read on the same cycle still takes the old byte
			ovr  <= rbf && !rx_rd;
			perr <= paren && par_bad;
			ferr <= !rxd;
		end else if (rx_rd) begin
			rbf  <= 1'b0;
			perr <= 1'b0;
			ferr <= 1'b0;
			ovr  <= 1'b0;
		end
	end

endmodule

// ==== logic/uart_txer.sv ====
`timescale 1ns/1ps
/* Frame is start, 8 data bits LSB first, optional parity, one stop bit
   Single holding register; a write while tbe is low replaces the pending byte */
module uart_txer (
	input  logic                  sys_clk,
	input  logic                  resetl,
	input  logic                  tick16,
	input  uart2_pkg::uart_byte_t tx_data,
	input  logic                  tx_wr,
	input  logic                  paren,
	input  logic                  even,
	input  logic                  pol,
	input  logic                  brk,
	output logic                  serout,
	output logic                  tbe,
	output logic                  tidle
);
	import uart2_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		START,
		DATA,
		PARITY,
		STOP
	} tx_state_t;

	tx_state_t  state;
	uart_byte_t hold;
	uart_byte_t shreg;
	logic [3:0] phase;
	logic [2:0] bitcnt;
	logic       par;
	logic       line;
	logic       load;
	logic       bit_end;

	// Pending byte goes to the shifter on the first tick seen while idle
	assign load = tick16 && (state == IDLE) && !tbe;

	// Last tick of the current bit cell
	assign bit_end = tick16 && (phase == 4'd15);

	// Holding register, loaded straight from the bus
	always_ff @(posedge sys_clk) begin
		if (tx_wr) begin
			hold <= tx_data;
		end
	end

	// Empty flag; a bus write wins over a same-cycle load
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			tbe <= 1'b1;
		end else if (tx_wr) begin
			tbe <= 1'b0;
		end else if (load) begin
			tbe <= 1'b1;
		end
	end

	// Frame sequencer, 16 ticks per bit
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state  <= IDLE;
			phase  <= '0;
			bitcnt <= '0;
		end else if (load) begin
			// Start bit begins on the load tick
			state  <= START;
			phase  <= '0;
			bitcnt <= '0;
		end else if (tick16 && (state != IDLE)) begin
			phase <= phase + 4'd1;
			if (bit_end) begin
				case (state)
					START: begin
						state <= DATA;
					end
					DATA: begin
						bitcnt <= bitcnt + 3'd1;
						if (bitcnt == 3'd7) begin
							state <= paren ? PARITY : STOP;
						end
					end
					PARITY: begin
						state <= STOP;
					end
					default: begin
						state <= IDLE;
					end
				endcase
			end
		end
	end

	// Shift register and running parity
	always_ff @(posedge sys_clk) begin
		if (load) begin
			// Seed of 1 gives odd parity
			shreg <= hold;
			par   <= ~even;
		end else if (bit_end && (state == DATA)) begin
			shreg <= {1'b0, shreg[7:1]};
			par   <= par ^ shreg[0];
		end
	end

	// Internal line level before polarity
	always_comb begin
		case (state)
			START:   line = 1'b0;
			DATA:    line = shreg[0];
			PARITY:  line = par;
			default: line = 1'b1;
		endcase
		// Break pulls the line low at once, whatever the sequencer does
		if (brk) begin
			line = 1'b0;
		end
	end

	// Polarity applied last
	assign serout = line ^ pol;
	assign tidle  = (state == IDLE);

endmodule

// ==== uart2.f ====
logic/uart2_pkg.sv
logic/uart_baud_gen.sv
logic/uart_txer.sv
logic/uart_rxer.sv
logic/uart_regs.sv
logic/uart2_top.sv
verif/uart2_tb.sv

// ==== verif/uart2_tb.sv ====
`timescale 1ns/1ps
/* Loopback testbench where serout feeds serin and the divisor stays at its reset value of 3
   Frames are decoded from serout with a fixed bit time of 16 x (div+1) cycles */
module uart2_tb;
	import uart2_pkg::*;

	localparam uart_div_t DIV  = 16'd3;
	localparam int CLK_PERIOD  = 8;
	localparam int BIT_CYCLES  = 16 * (DIV + 1);
	localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
	// Longest frame has a parity bit
	localparam int LONG_FRAME  = 11 * BIT_CYCLES;
	// Frames over all tests with break and idle stretches counted as frames
	localparam int NUM_FRAMES  = 24;
	localparam int WATCHDOG_NS = 5 * NUM_FRAMES * LONG_FRAME * CLK_PERIOD;

	logic       sys_clk;
	logic       resetl;
	logic       cyc;
	logic       stb;
	logic       we;
	uart_addr_t adr;
	uart_word_t dat_w;
	uart_word_t dat_r;
	logic       ack;
	logic       serout;
	wire        loop_line;
	int         checks;
	int         errors;
	string      test_name;

	// Serial loopback
	assign loop_line = serout;

	uart2_top #(
		.DIV_RESET(DIV)
	) uut (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.serout(serout),
		.serin(loop_line)
	);

	initial sys_clk = 1'b0;
	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Test failed");
		$finish;
	end

	task automatic compare(input string what, input uart_word_t exp, input uart_word_t act);
		checks = checks + 1;
		if (act !== exp) begin
			errors = errors + 1;
			$display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	// One classic cycle with inputs changed on the falling edge and ack due a cycle later
	task automatic bus_cycle(input logic w, input uart_addr_t a, input uart_word_t d,
			output uart_word_t q);
		int lat;
		@(negedge sys_clk);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = w;
		adr   = a;
		dat_w = d;
		lat   = 0;
		do begin
			@(negedge sys_clk);
			lat = lat + 1;
		end while (!ack && lat < 8);
		q   = dat_r;
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
		if (!ack) begin
			errors = errors + 1;
			$display("%s: no ack from the bus slave at address %0d", test_name, a);
		end else begin
			compare("ack latency", 16'd1, uart_word_t'(lat));
		end
	endtask

	task automatic wb_write(input uart_addr_t a, input uart_word_t d);
		uart_word_t unused;
		bus_cycle(1'b1, a, d, unused);
	endtask

	task automatic wb_read(input uart_addr_t a, output uart_word_t q);
		bus_cycle(1'b0, a, 16'h0000, q);
	endtask

	// Poll status until every bit of mask is set
	// Each read takes two cycles so the limit spans about four long frames
	task automatic wait_status(input uart_word_t mask, output uart_word_t st);
		int n;
		n = 0;
		do begin
			wb_read(ADDR_STAT, st);
			n = n + 1;
		end while (((st & mask) != mask) && n < 2 * LONG_FRAME);
		if ((st & mask) != mask) begin
			errors = errors + 1;
			$display("%s: status bits %h were never set", test_name, mask);
		end
	endtask

	task automatic wait_rbf(output uart_word_t st);
		wait_status(uart_word_t'(1 << STAT_RBF), st);
	endtask

	// Raw serout levels with the start bit in bit 0
	task automatic decode_line(input logic p, input int nbits, output logic [10:0] bits);
		int n;
		bits = '0;
		n    = 0;
		while ((serout ^ p) !== 1'b0 && n < 4 * BIT_CYCLES) begin
			@(negedge sys_clk);
			n = n + 1;
		end
		if ((serout ^ p) !== 1'b0) begin
			errors = errors + 1;
			$display("%s: no start bit seen on serout", test_name);
		end
		// Move to the middle of the start bit
		repeat (BIT_CYCLES / 2) @(negedge sys_clk);
		for (int i = 0; i < nbits; i++) begin
			bits[i] = serout;
			if (i < nbits - 1) begin
				repeat (BIT_CYCLES) @(negedge sys_clk);
			end
		end
	endtask

	// Expected frame before polarity; even parity keeps the count of ones even
	function automatic logic [10:0] frame_bits(input uart_byte_t d, input logic pe,
			input logic ev);
		logic [10:0] f;
		f      = '1;
		f[0]   = 1'b0;
		f[8:1] = d;
		if (pe) begin
			f[9] = ev ? ^d : ~^d;
		end
		return f;
	endfunction

	// serout must stay at one level for the given number of cycles
	task automatic hold_line(input logic level, input int cycles, input string what);
		int good;
		good = 0;
		repeat (cycles) begin
			@(negedge sys_clk);
			if (serout === level) begin
				good = good + 1;
			end
		end
		compare(what, uart_word_t'(cycles), uart_word_t'(good));
	endtask

	// Send one byte under the control bits already written and check both ends
	task automatic send_and_check(input uart_byte_t d, input logic pe, input logic ev,
			input logic p);
		logic [10:0] bits;
		logic [10:0] exp;
		uart_word_t  st;
		uart_word_t  rd;
		wb_write(ADDR_DATA, {8'h00, d});
		decode_line(p, pe ? 11 : 10, bits);
		exp = frame_bits(d, pe, ev) ^ {11{p}};
		// Nothing decoded past the stop bit
		if (!pe) begin
			exp[10] = 1'b0;
		end
		compare("serout frame", uart_word_t'(exp), uart_word_t'(bits));
		wait_rbf(st);
		compare("perr", 16'd0, uart_word_t'(st[STAT_PERR]));
		compare("ferr", 16'd0, uart_word_t'(st[STAT_FERR]));
		compare("ovr", 16'd0, uart_word_t'(st[STAT_OVR]));
		wb_read(ADDR_DATA, rd);
		compare("rx data", {8'h00, d}, rd);
	endtask

	task automatic reset_state;
		uart_word_t rd;
		test_name = "reset";
		wb_read(ADDR_STAT, rd);
		// tbe and tidle only
		compare("status", 16'h0003, rd);
		wb_read(ADDR_CTRL, rd);
		compare("control", 16'h0000, rd);
		wb_read(ADDR_DIV, rd);
		compare("divisor", DIV, rd);
	endtask

	task automatic plain_frames;
		logic [31:0] rnd;
		test_name = "plain";
		repeat (10) begin
			rnd = $urandom;
			send_and_check(rnd[7:0], 1'b0, 1'b0, 1'b0);
		end
	endtask

	task automatic parity_modes;
		logic [31:0] rnd;
		test_name = "parity even";
		wb_write(ADDR_CTRL, uart_word_t'((1 << CTRL_PAREN) | (1 << CTRL_EVEN)));
		repeat (2) begin
			rnd = $urandom;
			send_and_check(rnd[7:0], 1'b1, 1'b1, 1'b0);
		end
		test_name = "parity odd";
		wb_write(ADDR_CTRL, uart_word_t'(1 << CTRL_PAREN));
		repeat (2) begin
			rnd = $urandom;
			send_and_check(rnd[7:0], 1'b1, 1'b0, 1'b0);
		end
		wb_write(ADDR_CTRL, 16'h0000);
	endtask

	task automatic inverted_line;
		logic [31:0] rnd;
		test_name = "polarity";
		wb_write(ADDR_CTRL, uart_word_t'(1 << CTRL_POL));
		// Receiver also drops the false edge from the switch here
		hold_line(1'b0, BIT_CYCLES, "inverted idle cycles");
		repeat (2) begin
			rnd = $urandom;
			send_and_check(rnd[7:0], 1'b0, 1'b0, 1'b1);
		end
		wb_write(ADDR_CTRL, 16'h0000);
		hold_line(1'b1, BIT_CYCLES, "normal idle cycles");
	endtask

	task automatic line_break;
		uart_word_t st;
		uart_word_t rd;
		test_name = "break";
		wb_write(ADDR_CTRL, uart_word_t'(1 << CTRL_BRK));
		hold_line(1'b0, 2 * FRAME_CYCLES, "break low cycles");
		wb_write(ADDR_CTRL, 16'h0000);
		wb_read(ADDR_STAT, st);
		compare("rbf", 16'd1, uart_word_t'(st[STAT_RBF]));
		compare("ferr", 16'd1, uart_word_t'(st[STAT_FERR]));
		compare("perr", 16'd0, uart_word_t'(st[STAT_PERR]));
		wb_read(ADDR_DATA, rd);
		compare("rx data", 16'h0000, rd);
		wb_read(ADDR_STAT, st);
		compare("status after read", 16'h0003, st);
	endtask

	// Filler byte keeps the shifter busy so tbe is still low after each write
	task automatic overrun_flag;
		logic [31:0] rnd;
		uart_word_t  fill;
		uart_word_t  first;
		uart_word_t  second;
		uart_word_t  st;
		uart_word_t  rd;
		test_name = "overrun";
		rnd    = $urandom;
		fill   = {8'h00, rnd[7:0]};
		first  = {8'h00, rnd[15:8]};
		second = {8'h00, rnd[23:16]};
		wb_write(ADDR_DATA, fill);
		wait_status(uart_word_t'(1 << STAT_TBE), st);
		wb_write(ADDR_DATA, first);
		wb_read(ADDR_STAT, st);
		compare("tbe after first write", 16'd0, uart_word_t'(st[STAT_TBE]));
		wait_rbf(st);
		wb_read(ADDR_DATA, rd);
		compare("filler byte", fill, rd);
		wait_status(uart_word_t'(1 << STAT_TBE), st);
		wb_write(ADDR_DATA, second);
		wb_read(ADDR_STAT, st);
		compare("tbe after second write", 16'd0, uart_word_t'(st[STAT_TBE]));
		// Both frames out and neither read
		wait_status(uart_word_t'((1 << STAT_TBE) | (1 << STAT_TIDLE)), st);
		compare("rbf", 16'd1, uart_word_t'(st[STAT_RBF]));
		compare("ovr", 16'd1, uart_word_t'(st[STAT_OVR]));
		wb_read(ADDR_DATA, rd);
		compare("second byte", second, rd);
		wb_read(ADDR_STAT, st);
		compare("status after read", 16'h0003, st);
	endtask

	initial begin
		void'($urandom(23));
		checks    = 0;
		errors    = 0;
		test_name = "init";
		resetl    = 1'b0;
		cyc       = 1'b0;
		stb       = 1'b0;
		we        = 1'b0;
		adr       = '0;
		dat_w     = '0;
		repeat (5) @(posedge sys_clk);
		@(negedge sys_clk);
		resetl = 1'b1;

		reset_state();
		plain_frames();
		parity_modes();
		inverted_line();
		line_break();
		overrun_flag();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
